/* logic/vcache_dram_pkg.sv */
/*
  Shared widths and the DMA address word for the vcache to test DRAM path.
  The address union gives the cache DMA field order and the DRAM field order
  over the same 14 bits; a conversion reads one view and fills the other.
*/
package vcache_dram_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data and address field widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_W = 32;

  localparam int BA_W = 2;
  localparam int BG_W = 2;
  localparam int RO_W = 4;
  localparam int CO_W = 4;
  // byte offset inside one DMA word
  localparam int BO_W = 2;

  localparam int ADDR_W = BA_W + BG_W + RO_W + CO_W + BO_W;

  // word index into the test DRAM, byte offset dropped
  localparam int WORD_IDX_W = ADDR_W - BO_W;

  ////////////////////////////////////////////////////////////////////////////
  // address word, two decodings
  ////////////////////////////////////////////////////////////////////////////

  typedef union packed {
    // as it leaves the cache DMA
    struct packed {
      logic [BA_W-1:0] ba;
      logic [BG_W-1:0] bg;
      logic [RO_W-1:0] ro;
      logic [CO_W-1:0] co;
      logic [BO_W-1:0] bo;
    } cache_order;
    // as the DRAM channel maps it
    struct packed {
      logic [RO_W-1:0] ro;
      logic [BG_W-1:0] bg;
      logic [BA_W-1:0] ba;
      logic [CO_W-1:0] co;
      logic [BO_W-1:0] bo;
    } dram_order;
  } dram_addr_u;

endpackage

/* logic/vcache_dma_arbiter.sv */
/*
  Round-robin arbiter for the vcache DMA ports sharing one test DRAM channel.
  Grants at most one request per cycle through a combinational yumi and
  forwards the winner to memory; granted reads push the winner's id.
*/
`timescale 1ns/1ns

module vcache_dma_arbiter #(
  parameter int N_CACHES_P = 4
  ,localparam int ID_W_LP = $clog2(N_CACHES_P)
) (
  input  logic clk_i
  ,input logic rst_i

  ,input  logic [N_CACHES_P-1:0]                              req_v_i
  ,input  logic [N_CACHES_P-1:0]                              write_not_read_i
  ,input  vcache_dram_pkg::dram_addr_u [N_CACHES_P-1:0]       addr_i
  ,input  logic [N_CACHES_P-1:0][vcache_dram_pkg::DATA_W-1:0] wdata_i
  ,output logic [N_CACHES_P-1:0]                              yumi_o

  ,output logic                                mem_v_o
  ,output logic                                mem_write_not_read_o
  ,output vcache_dram_pkg::dram_addr_u         mem_addr_o
  ,output logic [vcache_dram_pkg::DATA_W-1:0]  mem_wdata_o

  ,output logic               push_v_o
  ,output logic [ID_W_LP-1:0] push_id_o
);

  // port granted most recently
  logic [ID_W_LP-1:0] last_q;

  logic               grant_found;
  logic [ID_W_LP-1:0] grant_id;

  // search upward from the port after last_q, wrapping around
  always_comb begin
    int idx;
    grant_found = 1'b0;
    grant_id    = '0;
    for (int i = 1; i <= N_CACHES_P; i++) begin
      idx = (int'(last_q) + i) % N_CACHES_P;
      if (!grant_found && req_v_i[idx]) begin
        grant_found = 1'b1;
        grant_id    = ID_W_LP'(idx);
      end
    end
  end

  always_comb begin
    yumi_o = '0;
    if (grant_found) begin
      yumi_o[grant_id] = 1'b1;
    end
  end

  // winner's request straight to the test DRAM, which never stalls
  assign mem_v_o              = grant_found;
  assign mem_write_not_read_o = write_not_read_i[grant_id];
  assign mem_addr_o           = addr_i[grant_id];
  assign mem_wdata_o          = wdata_i[grant_id];

  // reads remember who asked
  assign push_v_o  = grant_found & ~write_not_read_i[grant_id];
  assign push_id_o = grant_id;

  // start at N-1 so that port 0 is searched first after reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_q <= ID_W_LP'(N_CACHES_P - 1);
    end else if (grant_found) begin
      last_q <= grant_id;
    end
  end

endmodule

/* logic/test_dram.sv */
/*
  Single-channel test DRAM model, one DATA_W word per access.
  Takes cache-order addresses and stores in DRAM order. Writes land at the
  accepting edge; a read accepted at edge t shows valid, data and its DRAM-order
  address on the read_done outputs when sampled at edge t + READ_LATENCY_P.
*/
`timescale 1ns/1ns

module test_dram #(
  parameter int READ_LATENCY_P = 3
) (
  input  logic clk_i
  ,input logic rst_i

  ,input logic                                v_i
  ,input logic                                write_not_read_i
  ,input vcache_dram_pkg::dram_addr_u         addr_i
  ,input logic [vcache_dram_pkg::DATA_W-1:0]  wdata_i

  ,output logic                                read_done_v_o
  ,output logic [vcache_dram_pkg::DATA_W-1:0]  read_data_o
  ,output vcache_dram_pkg::dram_addr_u         read_done_addr_o
);

  import vcache_dram_pkg::*;

  dram_addr_u            dram_addr;
  logic [WORD_IDX_W-1:0] word_idx;

  logic [DATA_W-1:0] mem [2**WORD_IDX_W];

  // read pipe, stage 0 loads at the accepting edge
  logic [READ_LATENCY_P-1:0] rd_v_q;
  logic [DATA_W-1:0]         rd_data_q [READ_LATENCY_P];
  dram_addr_u                rd_addr_q [READ_LATENCY_P];

  ////////////////////////////////////////////////////////////////////////////
  // cache order to DRAM order
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    dram_addr.dram_order.ro = addr_i.cache_order.ro;
    dram_addr.dram_order.bg = addr_i.cache_order.bg;
    dram_addr.dram_order.ba = addr_i.cache_order.ba;
    dram_addr.dram_order.co = addr_i.cache_order.co;
    dram_addr.dram_order.bo = addr_i.cache_order.bo;
  end

  // row, bank group, bank, column select the word
  assign word_idx = dram_addr[ADDR_W-1:BO_W];

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  // test memory powers up cleared
  initial begin
    for (int i = 0; i < 2**WORD_IDX_W; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && write_not_read_i) begin
      mem[word_idx] <= wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read latency pipe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_v_q <= '0;
    end else begin
      rd_v_q[0] <= v_i & ~write_not_read_i;
      for (int k = 1; k < READ_LATENCY_P; k++) begin
        rd_v_q[k] <= rd_v_q[k-1];
      end
    end
  end

  // data sampled at acceptance, one write per cycle so no same-edge hazard
  always_ff @(posedge clk_i) begin
    rd_data_q[0] <= mem[word_idx];
    rd_addr_q[0] <= dram_addr;
    for (int k = 1; k < READ_LATENCY_P; k++) begin
      rd_data_q[k] <= rd_data_q[k-1];
      rd_addr_q[k] <= rd_addr_q[k-1];
    end
  end

  assign read_done_v_o    = rd_v_q[READ_LATENCY_P-1];
  assign read_data_o      = rd_data_q[READ_LATENCY_P-1];
  assign read_done_addr_o = rd_addr_q[READ_LATENCY_P-1];

endmodule

/* logic/dram_read_return.sv */
/*
  Steers returning DRAM read data back to the DMA port that issued the read.
  Requester ids queue in issue order; each read_done pops the oldest id and
  raises that port's valid in the same cycle.
*/
`timescale 1ns/1ns

module dram_read_return #(
  parameter int N_CACHES_P = 4
  ,parameter int READ_LATENCY_P = 3
  ,localparam int ID_W_LP = $clog2(N_CACHES_P)
) (
  input  logic clk_i
  ,input logic rst_i

  ,input logic               push_v_i
  ,input logic [ID_W_LP-1:0] push_id_i

  ,input logic                                read_done_v_i
  ,input logic [vcache_dram_pkg::DATA_W-1:0]  read_data_i

  ,output logic [vcache_dram_pkg::DATA_W-1:0] rdata_o
  ,output logic [N_CACHES_P-1:0]              rdata_v_o
);

  // room for every read in flight plus one pushed on the popping edge
  localparam int DEPTH_LP = READ_LATENCY_P + 1;
  localparam int PTR_W_LP = $clog2(DEPTH_LP);

  logic [ID_W_LP-1:0]  id_mem [DEPTH_LP];
  logic [PTR_W_LP-1:0] wr_ptr_q;
  logic [PTR_W_LP-1:0] rd_ptr_q;

  function automatic logic [PTR_W_LP-1:0] ptr_next(input logic [PTR_W_LP-1:0] ptr);
    if (ptr == PTR_W_LP'(DEPTH_LP - 1)) begin
      return '0;
    end
    return PTR_W_LP'(ptr + 1'b1);
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_v_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (read_done_v_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_v_i) begin
      id_mem[wr_ptr_q] <= push_id_i;
    end
  end

  // oldest id decoded one-hot
  always_comb begin
    rdata_v_o = '0;
    if (read_done_v_i) begin
      rdata_v_o[id_mem[rd_ptr_q]] = 1'b1;
    end
  end

  // data bus shared by all ports
  assign rdata_o = read_data_i;

endmodule

/* logic/vcache_dram_top.sv */
/*
  Vcache DMA ports sharing one test DRAM channel.
  Requests arbitrate round-robin, the test DRAM serves them in DRAM address
  order, and read data returns in order to the requesting port.
*/
`timescale 1ns/1ns

module vcache_dram_top #(
  parameter int N_CACHES_P = 4
  ,parameter int READ_LATENCY_P = 3
) (
  input  logic clk_i
  ,input logic rst_i

  ,input  logic [N_CACHES_P-1:0]                              dma_req_v_i
  ,input  logic [N_CACHES_P-1:0]                              dma_write_not_read_i
  ,input  vcache_dram_pkg::dram_addr_u [N_CACHES_P-1:0]       dma_addr_i
  ,input  logic [N_CACHES_P-1:0][vcache_dram_pkg::DATA_W-1:0] dma_wdata_i
  ,output logic [N_CACHES_P-1:0]                              dma_req_yumi_o

  ,output logic [vcache_dram_pkg::DATA_W-1:0] dma_rdata_o
  ,output logic [N_CACHES_P-1:0]              dma_rdata_v_o
);

  import vcache_dram_pkg::*;

  localparam int ID_W_LP = $clog2(N_CACHES_P);

  // arbiter to test DRAM
  logic              mem_v;
  logic              mem_write_not_read;
  dram_addr_u        mem_addr;
  logic [DATA_W-1:0] mem_wdata;

  // arbiter to return queue
  logic               push_v;
  logic [ID_W_LP-1:0] push_id;

  // test DRAM read completion
  logic              read_done_v;
  logic [DATA_W-1:0] read_data;

  vcache_dma_arbiter #(
    .N_CACHES_P(N_CACHES_P)
  ) u_arb (
    .clk_i                  (clk_i)
    ,.rst_i                 (rst_i)
    ,.req_v_i               (dma_req_v_i)
    ,.write_not_read_i      (dma_write_not_read_i)
    ,.addr_i                (dma_addr_i)
    ,.wdata_i               (dma_wdata_i)
    ,.yumi_o                (dma_req_yumi_o)
    ,.mem_v_o               (mem_v)
    ,.mem_write_not_read_o  (mem_write_not_read)
    ,.mem_addr_o            (mem_addr)
    ,.mem_wdata_o           (mem_wdata)
    ,.push_v_o              (push_v)
    ,.push_id_o             (push_id)
  );

  test_dram #(
    .READ_LATENCY_P(READ_LATENCY_P)
  ) u_dram (
    .clk_i              (clk_i)
    ,.rst_i             (rst_i)
    ,.v_i               (mem_v)
    ,.write_not_read_i  (mem_write_not_read)
    ,.addr_i            (mem_addr)
    ,.wdata_i           (mem_wdata)
    ,.read_done_v_o     (read_done_v)
    ,.read_data_o       (read_data)
    ,.read_done_addr_o  ()
  );

  dram_read_return #(
    .N_CACHES_P(N_CACHES_P)
    ,.READ_LATENCY_P(READ_LATENCY_P)
  ) u_ret (
    .clk_i           (clk_i)
    ,.rst_i          (rst_i)
    ,.push_v_i       (push_v)
    ,.push_id_i      (push_id)
    ,.read_done_v_i  (read_done_v)
    ,.read_data_i    (read_data)
    ,.rdata_o        (dma_rdata_o)
    ,.rdata_v_o      (dma_rdata_v_o)
  );

endmodule

/* verification/vcache_dram_sva.sv */
/*
  Arbiter assertions, bound into every vcache_dma_arbiter instance.
  Checks that at most one yumi is raised and only toward a requesting port.
*/
`timescale 1ns/1ns

module vcache_dram_sva #(
  parameter int N_CACHES_P = 4
) (
  input  logic clk_i
  ,input logic rst_i
  ,input logic [N_CACHES_P-1:0] req_v_i
  ,input logic [N_CACHES_P-1:0] yumi_i
);

  // one grant per cycle at most
  yumi_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(yumi_i))
    else $error("more than one DMA port granted in one cycle");

  // a grant only answers a held request
  yumi_needs_req: assert property (
    @(posedge clk_i) disable iff (rst_i) (yumi_i & ~req_v_i) == '0
  ) else $error("yumi raised on a port without a valid request");

endmodule

bind vcache_dma_arbiter vcache_dram_sva #(
  .N_CACHES_P(N_CACHES_P)
) u_sva (
  .clk_i     (clk_i)
  ,.rst_i    (rst_i)
  ,.req_v_i  (req_v_i)
  ,.yumi_i   (yumi_o)
);

/* verification/vcache_dram_tb.sv */
/*
  Testbench for the vcache DMA to test DRAM path. Drives the DMA ports,
  predicts grants and read returns with a memory and round-robin model, and
  compares every cycle at the falling edge. Built through the project file list.
*/
`timescale 1ns/1ns

module vcache_dram_tb;

  import vcache_dram_pkg::*;

  localparam int N_CACHES = 4;
  localparam int READ_LAT = 3;
  localparam int FAIR_CYCLES = 40;
  localparam int RAND_CYCLES = 300;
  // directed requests plus at most one new request per port per cycle
  localparam int TOTAL_REQ = 3 + N_CACHES * (FAIR_CYCLES + RAND_CYCLES + 2);
  localparam int WATCHDOG_CYCLES = TOTAL_REQ * N_CACHES + READ_LAT + 10;
  // bank and bank group random, one bit each of row and column, ro[3] never set
  localparam logic [ADDR_W-1:0] ADDR_MASK = 14'b11_11_0001_0001_11;
  localparam logic [ADDR_W-1:0] ADDR_UNUSED = 14'b00_00_1000_0000_00;

  logic clk = 1'b0;
  logic rst;
  logic [N_CACHES-1:0]             dma_req_v;
  logic [N_CACHES-1:0]             dma_wnr;
  dram_addr_u [N_CACHES-1:0]       dma_addr;
  logic [N_CACHES-1:0][DATA_W-1:0] dma_wdata;
  logic [N_CACHES-1:0]             dma_yumi;
  logic [DATA_W-1:0]               dma_rdata;
  logic [N_CACHES-1:0]             dma_rdata_v;

  // reference model state
  logic [DATA_W-1:0] model_mem [2**WORD_IDX_W];
  int                last_grant;
  logic [DATA_W-1:0] pend_data [$];
  int                pend_port [$];
  int                pend_due [$];

  int    cyc;
  string test_name;
  int    err_onehot;
  int    err_data;

  vcache_dram_top #(
    .N_CACHES_P(N_CACHES)
    ,.READ_LATENCY_P(READ_LAT)
  ) u_dut (
    .clk_i                  (clk)
    ,.rst_i                 (rst)
    ,.dma_req_v_i           (dma_req_v)
    ,.dma_write_not_read_i  (dma_wnr)
    ,.dma_addr_i            (dma_addr)
    ,.dma_wdata_i           (dma_wdata)
    ,.dma_req_yumi_o        (dma_yumi)
    ,.dma_rdata_o           (dma_rdata)
    ,.dma_rdata_v_o         (dma_rdata_v)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference functions and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // word index from the row, bank group, bank, column order
  function automatic int dram_word_index(input logic [ADDR_W-1:0] a);
    int co;
    int ro;
    int bg;
    int ba;
    co = int'(a[BO_W +: CO_W]);
    ro = int'(a[BO_W+CO_W +: RO_W]);
    bg = int'(a[BO_W+CO_W+RO_W +: BG_W]);
    ba = int'(a[BO_W+CO_W+RO_W+BG_W +: BA_W]);
    return ((ro * 2**BG_W + bg) * 2**BA_W + ba) * 2**CO_W + co;
  endfunction

  // first requester after the last grant, -1 when idle
  function automatic int next_grant(input int last, input logic [N_CACHES-1:0] req);
    int p;
    for (int i = 1; i <= N_CACHES; i++) begin
      p = (last + i) % N_CACHES;
      if (req[p]) begin
        return p;
      end
    end
    return -1;
  endfunction

  task automatic check_onehot(input string name, input logic [N_CACHES-1:0] exp,
                              input logic [N_CACHES-1:0] act);
    if (act !== exp) begin
      err_onehot++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      err_data++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // model update and compare, outputs are settled at the falling edge
  always @(negedge clk) begin
    logic [N_CACHES-1:0] exp_v;
    logic [N_CACHES-1:0] exp_yumi;
    int gid;
    int widx;
    exp_v    = '0;
    exp_yumi = '0;
    if (rst) begin
      last_grant = N_CACHES - 1;
      pend_data.delete();
      pend_port.delete();
      pend_due.delete();
      check_onehot({test_name, " yumi"}, '0, dma_yumi);
      check_onehot({test_name, " rdata_v"}, '0, dma_rdata_v);
    end else begin
      if (pend_due.size() != 0 && pend_due[0] == cyc) begin
        exp_v[pend_port[0]] = 1'b1;
      end
      check_onehot({test_name, " rdata_v"}, exp_v, dma_rdata_v);
      if (exp_v != '0) begin
        check_data({test_name, " rdata"}, pend_data[0], dma_rdata);
        void'(pend_data.pop_front());
        void'(pend_port.pop_front());
        void'(pend_due.pop_front());
      end
      gid = next_grant(last_grant, dma_req_v);
      if (gid >= 0) begin
        exp_yumi[gid] = 1'b1;
      end
      check_onehot({test_name, " yumi"}, exp_yumi, dma_yumi);
      // accepted at the coming rising edge
      if (gid >= 0) begin
        last_grant = gid;
        widx = dram_word_index(dma_addr[gid]);
        if (dma_wnr[gid]) begin
          model_mem[widx] = dma_wdata[gid];
        end else begin
          pend_data.push_back(model_mem[widx]);
          pend_port.push_back(gid);
          pend_due.push_back(cyc + READ_LAT);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic do_request(input int port, input logic wnr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata);
    @(posedge clk);
    dma_req_v[port] <= 1'b1;
    dma_wnr[port]   <= wnr;
    dma_addr[port]  <= addr;
    dma_wdata[port] <= wdata;
    while (1) begin
      @(negedge clk);
      if (dma_yumi[port]) begin
        break;
      end
    end
    @(posedge clk);
    dma_req_v[port] <= 1'b0;
  endtask

  task automatic new_request(input int port, input logic valid);
    dma_req_v[port] <= valid;
    dma_wnr[port]   <= 1'($urandom);
    dma_addr[port]  <= ADDR_W'($urandom) & ADDR_MASK;
    dma_wdata[port] <= $urandom;
  endtask

  // idle or just-granted ports pick a new request every cycle
  task automatic drive_random(input int cycles, input logic all_valid);
    logic [N_CACHES-1:0] taken;
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk);
      taken = dma_yumi;
      @(posedge clk);
      for (int p = 0; p < N_CACHES; p++) begin
        if (!dma_req_v[p] || taken[p]) begin
          new_request(p, all_valid || (($urandom % 4) != 0));
        end
      end
    end
    // held requests still wait for their yumi
    while (1) begin
      @(negedge clk);
      if (dma_req_v == '0) begin
        break;
      end
      taken = dma_yumi;
      @(posedge clk);
      dma_req_v <= dma_req_v & ~taken;
    end
  endtask

  task automatic wait_reads_done();
    while (pend_port.size() != 0) begin
      @(negedge clk);
    end
  endtask

  initial begin
    logic [ADDR_W-1:0] addr_a;
    logic [DATA_W-1:0] data_a;
    void'($urandom(24));
    rst        = 1'b1;
    dma_req_v  = '0;
    dma_wnr    = '0;
    dma_addr   = '0;
    dma_wdata  = '0;
    cyc        = 0;
    err_onehot = 0;
    err_data   = 0;
    last_grant = N_CACHES - 1;
    for (int i = 0; i < 2**WORD_IDX_W; i++) begin
      model_mem[i] = '0;
    end

    test_name = "reset";
    apply_reset();
    repeat (2) @(negedge clk);

    test_name = "single port";
    addr_a = ADDR_W'($urandom) & ADDR_MASK;
    data_a = $urandom;
    do_request(1, 1'b1, addr_a, data_a);
    do_request(1, 1'b0, addr_a, '0);
    wait_reads_done();

    test_name = "unwritten memory";
    do_request(2, 1'b0, ADDR_UNUSED, '0);
    wait_reads_done();

    test_name = "fair grants";
    apply_reset();
    drive_random(FAIR_CYCLES, 1'b1);
    wait_reads_done();

    test_name = "reads in flight";
    drive_random(RAND_CYCLES, 1'b0);
    wait_reads_done();

    $display("errors: valid/grant %0d, data %0d", err_onehot, err_data);
    if (err_onehot + err_data == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* vcache_dram.f */
logic/vcache_dram_pkg.sv
logic/vcache_dma_arbiter.sv
logic/test_dram.sv
logic/dram_read_return.sv
logic/vcache_dram_top.sv
verification/vcache_dram_sva.sv
verification/vcache_dram_tb.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of the vcache DMA to test DRAM testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module vcache_dram_tb -f vcache_dram.f

if ! ./obj_dir/Vvcache_dram_tb > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
